/* list.f */
+incdir+tests
hw/cnn_types_pkg.sv
hw/frame_ctrl_pkg.sv
hw/coef_loader.sv
hw/line_window.sv
hw/tap_mac.sv
hw/channel_sum.sv
hw/frame_control.sv
hw/conv_layer1.sv
tests/conv_layer1_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run the conv_layer1 testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module conv_layer1_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed"
	exit $status
fi

./obj_dir/Vconv_layer1_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned failure status $status"
	exit $status
fi

exit 0

/* tests/conv_model.svh */
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// signed product floor-scaled by 2^FRAC_BITS with the low DATA_W bits kept.
function automatic data_t fixed_product(input data_t a, input data_t b);
	int full;
	full = int'(a) * int'(b);
	full = full >>> FRAC_BITS;
	return data_t'(full);
endfunction

// expected output word for result (r,c) taken from the memories of the testbench.
function automatic result_t expected_result(input int r, input int c);
	result_t           res;
	pixel_t            px;
	pixel_t            wt;
	logic [DATA_W-1:0] acc;
	for (int j = 0; j < OUT_CH; j++)
	begin
		acc = bias_mem[j];
		for (int dy = 0; dy < KERNEL; dy++)
		begin
			for (int dx = 0; dx < KERNEL; dx++)
			begin
				px = pixel_mem[(r + dy) * IMG_W + c + dx];
				wt = weight_mem[(KERNEL * dy + dx) * OUT_CH + j];   // word k holds tap k/8 and channel k%8.
				for (int i = 0; i < IN_CH; i++)
				begin
					acc = acc + fixed_product(data_t'(px[i]), data_t'(wt[i]));
				end
			end
		end
		res[j] = acc;
	end
	return res;
endfunction

task automatic check_result(input string name, input result_t got, input result_t exp);
	if (got !== exp)
	begin
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		$display("Simulation finished: FAIL");
		$fatal(1, "output word mismatch");
	end
endtask

task automatic check_coord(input string name, input logic [ADDR_W-1:0] got,
	input logic [ADDR_W-1:0] exp);
	if (got !== exp)
	begin
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		$display("Simulation finished: FAIL");
		$fatal(1, "address or count mismatch");
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		$display("Simulation finished: FAIL");
		$fatal(1, "control signal mismatch");
	end
endtask

`endif

/* tests/conv_layer1_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer1_tb;
	import cnn_types_pkg::*;
	import frame_ctrl_pkg::*;

	localparam logic [31:0] SEED    = 32'h9cfc_8c4f;
	localparam int          RESULTS = OUT_W * OUT_H;

	// selectors for wait_for_level.
	localparam int PIXEL_READ  = 0;
	localparam int WEIGHT_READ = 1;
	localparam int BIAS_READ   = 2;
	localparam int DONE_PULSE  = 3;

	logic              clk;
	logic              rst;
	logic              pixel_store_done;
	logic              weight_store_done;
	logic              bias_store_done;
	pixel_t            input_data = '0;
	pixel_t            weight_data = '0;
	data_t             bias_data = '0;
	logic              save_enable;
	logic [ADDR_W-1:0] output_row;
	logic [ADDR_W-1:0] output_col;
	result_t           output_data;
	logic              layer1_calculation_done;
	logic [ADDR_W-1:0] read_pixel_addr;
	logic [ADDR_W-1:0] read_weight_addr;
	logic [ADDR_W-1:0] read_bias_addr;
	logic              read_pixel_signal;
	logic              read_weight_signal;
	logic              read_bias_signal;

	pixel_t pixel_mem [FRAME_PIXELS];
	pixel_t weight_mem [WEIGHT_WORDS];
	data_t  bias_mem [BIAS_WORDS];

	int   pix_cnt = 0;
	int   weight_cnt = 0;
	int   bias_cnt = 0;
	int   res_cnt = 0;
	int   done_cnt = 0;
	logic pixel_prev = 1'b0;
	logic weight_prev = 1'b0;
	logic bias_prev = 1'b0;
	logic done_due = 1'b0;   // the last result was seen one cycle ago.

	`include "conv_model.svh"

	conv_layer1 UUT (
		.clk                     (clk),
		.rst                     (rst),
		.pixel_store_done        (pixel_store_done),
		.weight_store_done       (weight_store_done),
		.bias_store_done         (bias_store_done),
		.input_data              (input_data),
		.weight_data             (weight_data),
		.bias_data               (bias_data),
		.save_enable             (save_enable),
		.output_row              (output_row),
		.output_col              (output_col),
		.output_data             (output_data),
		.layer1_calculation_done (layer1_calculation_done),
		.read_pixel_addr         (read_pixel_addr),
		.read_weight_addr        (read_weight_addr),
		.read_bias_addr          (read_bias_addr),
		.read_pixel_signal       (read_pixel_signal),
		.read_weight_signal      (read_weight_signal),
		.read_bias_signal        (read_bias_signal)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// the registered memories return the word for an address one cycle later.
	always @(posedge clk)
	begin
		input_data  <= pixel_mem[read_pixel_addr];
		weight_data <= weight_mem[read_weight_addr];
		bias_data   <= bias_mem[read_bias_addr];
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	function automatic logic strobe_level(input int which);
		case (which)
			PIXEL_READ:  return read_pixel_signal;
			WEIGHT_READ: return read_weight_signal;
			BIAS_READ:   return read_bias_signal;
			default:     return layer1_calculation_done;
		endcase
	endfunction

	task automatic wait_for_level(input int which, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (strobe_level(which) !== level && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (strobe_level(which) !== level)
		begin
			stop_with_failure($sformatf("no %s within %0d cycles", what, limit));
		end
	endtask

	task automatic pulse_store(input logic pix, input logic wgt, input logic bia);
		@(posedge clk);
		pixel_store_done  <= pix;
		weight_store_done <= wgt;
		bias_store_done   <= bia;
		@(posedge clk);
		pixel_store_done  <= 1'b0;
		weight_store_done <= 1'b0;
		bias_store_done   <= 1'b0;
	endtask

	task automatic fill_memories();
		@(negedge clk);
		for (int k = 0; k < FRAME_PIXELS; k++)
		begin
			pixel_mem[k] = {16'($urandom()), 16'($urandom()), 16'($urandom())};
		end
		for (int k = 0; k < WEIGHT_WORDS; k++)
		begin
			weight_mem[k] = {16'($urandom()), 16'($urandom()), 16'($urandom())};
		end
		for (int k = 0; k < BIAS_WORDS; k++)
		begin
			bias_mem[k] = data_t'($urandom());
		end
	endtask

	task automatic quiet_after_reset(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			check_flag("read_pixel_signal", read_pixel_signal, 1'b0);
			check_flag("read_weight_signal", read_weight_signal, 1'b0);
			check_flag("read_bias_signal", read_bias_signal, 1'b0);
			check_flag("save_enable", save_enable, 1'b0);
			check_flag("layer1_calculation_done", layer1_calculation_done, 1'b0);
		end
	endtask

	task automatic load_coefs();
		pulse_store(1'b0, 1'b1, 1'b1);
		wait_for_level(WEIGHT_READ, 1'b1, 4, "rise of read_weight_signal");
		wait_for_level(BIAS_READ, 1'b1, 4, "rise of read_bias_signal");
		wait_for_level(WEIGHT_READ, 1'b0, WEIGHT_WORDS + 4, "fall of read_weight_signal");
		wait_for_level(BIAS_READ, 1'b0, 4, "fall of read_bias_signal");
		repeat (3) @(posedge clk);   // coefficients are final two cycles after the fall.
		check_coord("read_weight_signal cycles", ADDR_W'(weight_cnt), ADDR_W'(WEIGHT_WORDS));
		check_coord("read_bias_signal cycles", ADDR_W'(bias_cnt), ADDR_W'(BIAS_WORDS));
	endtask

	task automatic run_frame();
		int done_start;
		done_start = done_cnt;
		pulse_store(1'b1, 1'b0, 1'b0);
		wait_for_level(PIXEL_READ, 1'b1, 4, "rise of read_pixel_signal");
		wait_for_level(PIXEL_READ, 1'b0, FRAME_PIXELS + 4, "fall of read_pixel_signal");
		wait_for_level(DONE_PULSE, 1'b1, 8, "layer1_calculation_done pulse");
		repeat (4) @(posedge clk);
		check_coord("read_pixel_signal cycles", ADDR_W'(pix_cnt), ADDR_W'(FRAME_PIXELS));
		check_coord("save_enable cycles", ADDR_W'(res_cnt), ADDR_W'(RESULTS));
		check_coord("done pulses in frame", ADDR_W'(done_cnt - done_start), ADDR_W'(1));
	endtask

	// read strobes, results and the done pulse are all checked on the falling edge.
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (read_pixel_signal && !pixel_prev)
			begin
				pix_cnt = 0;
				res_cnt = 0;
			end
			if (read_weight_signal && !weight_prev)
			begin
				weight_cnt = 0;
			end
			if (read_bias_signal && !bias_prev)
			begin
				bias_cnt = 0;
			end
			if (read_pixel_signal)
			begin
				check_coord("read_pixel_addr", read_pixel_addr, ADDR_W'(pix_cnt));
				pix_cnt++;
			end
			if (read_weight_signal)
			begin
				check_coord("read_weight_addr", read_weight_addr, ADDR_W'(weight_cnt));
				weight_cnt++;
			end
			if (read_bias_signal)
			begin
				check_coord("read_bias_addr", read_bias_addr, ADDR_W'(bias_cnt));
				bias_cnt++;
			end
			check_flag("layer1_calculation_done", layer1_calculation_done, done_due);
			if (layer1_calculation_done)
			begin
				done_cnt++;
			end
			done_due = 1'b0;
			if (save_enable)
			begin
				if (res_cnt >= RESULTS)
				begin
					stop_with_failure("save_enable was high after the last result of the frame");
				end
				check_coord("output_row", output_row, ADDR_W'(res_cnt / OUT_W));
				check_coord("output_col", output_col, ADDR_W'(res_cnt % OUT_W));
				check_result($sformatf("output_data at (%0d,%0d)", res_cnt / OUT_W,
					res_cnt % OUT_W), output_data, expected_result(res_cnt / OUT_W,
					res_cnt % OUT_W));
				res_cnt++;
				done_due = (res_cnt == RESULTS);
			end
			pixel_prev  = read_pixel_signal;
			weight_prev = read_weight_signal;
			bias_prev   = read_bias_signal;
		end
	end

	initial
	begin
		rst               = 1'b1;
		pixel_store_done  = 1'b0;
		weight_store_done = 1'b0;
		bias_store_done   = 1'b0;
		void'($urandom(SEED));
		fill_memories();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		quiet_after_reset(10);
		load_coefs();
		run_frame();
		fill_memories();   // second frame runs on fresh weights, biases and pixels.
		load_coefs();
		run_frame();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/conv_layer1.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer1 (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             pixel_store_done,
	input  logic                             weight_store_done,
	input  logic                             bias_store_done,
	input  cnn_types_pkg::pixel_t            input_data,
	input  cnn_types_pkg::pixel_t            weight_data,
	input  cnn_types_pkg::data_t             bias_data,
	output logic                             save_enable,
	output logic [cnn_types_pkg::ADDR_W-1:0] output_row,
	output logic [cnn_types_pkg::ADDR_W-1:0] output_col,
	output cnn_types_pkg::result_t           output_data,
	output logic                             layer1_calculation_done,
	output logic [cnn_types_pkg::ADDR_W-1:0] read_pixel_addr,
	output logic [cnn_types_pkg::ADDR_W-1:0] read_weight_addr,
	output logic [cnn_types_pkg::ADDR_W-1:0] read_bias_addr,
	output logic                             read_pixel_signal,
	output logic                             read_weight_signal,
	output logic                             read_bias_signal
);
	import cnn_types_pkg::*;
	import frame_ctrl_pkg::*;

	logic              window_shift;
	pixel_t            taps [TAPS];
	pixel_t            weight_coefs [WEIGHT_WORDS];
	logic [DATA_W-1:0] bias_coefs [BIAS_WORDS];
	tap_weights_t      tap_weights [TAPS];
	channel_vec_t      tap_partials [TAPS];
	data_t             chan_partials [OUT_CH][TAPS];

	frame_control u_frame_control (
		.clk                     (clk),
		.rst                     (rst),
		.pixel_store_done        (pixel_store_done),
		.read_pixel_addr         (read_pixel_addr),
		.read_pixel_signal       (read_pixel_signal),
		.window_shift            (window_shift),
		.save_enable             (save_enable),
		.output_row              (output_row),
		.output_col              (output_col),
		.layer1_calculation_done (layer1_calculation_done)
	);

	line_window u_line_window (
		.clk   (clk),
		.rst   (rst),
		.pixel (input_data),
		.shift (window_shift),
		.taps  (taps)
	);

	coef_loader #(.WORDS(WEIGHT_WORDS), .WIDTH($bits(pixel_t))) u_weight_loader (
		.clk         (clk),
		.rst         (rst),
		.store_done  (weight_store_done),
		.data        (weight_data),
		.read_addr   (read_weight_addr),
		.read_signal (read_weight_signal),
		.coefs       (weight_coefs)
	);

	coef_loader #(.WORDS(BIAS_WORDS), .WIDTH(DATA_W)) u_bias_loader (
		.clk         (clk),
		.rst         (rst),
		.store_done  (bias_store_done),
		.data        (bias_data),
		.read_addr   (read_bias_addr),
		.read_signal (read_bias_signal),
		.coefs       (bias_coefs)
	);

	// weight word t*OUT_CH+j belongs to tap t and output channel j.
	for (genvar t = 0; t < TAPS; t++)
	begin : g_tap
		for (genvar j = 0; j < OUT_CH; j++)
		begin : g_ch
			assign tap_weights[t][j]   = weight_coefs[t*OUT_CH + j];
			assign chan_partials[j][t] = tap_partials[t][j];
		end

		tap_mac u_tap_mac (
			.pixel   (taps[t]),
			.weights (tap_weights[t]),
			.partial (tap_partials[t])
		);
	end

	for (genvar j = 0; j < OUT_CH; j++)
	begin : g_sum
		channel_sum u_channel_sum (
			.partials (chan_partials[j]),
			.bias     (data_t'(bias_coefs[j])),
			.sum      (output_data[j])
		);
	end

endmodule

`default_nettype wire

/* hw/frame_control.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_control (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             pixel_store_done,
	output logic [cnn_types_pkg::ADDR_W-1:0] read_pixel_addr,
	output logic                             read_pixel_signal,
	output logic                             window_shift,
	output logic                             save_enable,
	output logic [cnn_types_pkg::ADDR_W-1:0] output_row,
	output logic [cnn_types_pkg::ADDR_W-1:0] output_col,
	output logic                             layer1_calculation_done
);
	import cnn_types_pkg::*;
	import frame_ctrl_pkg::*;

	localparam logic [ADDR_W-1:0] LAST_PIXEL = ADDR_W'(FRAME_PIXELS - 1);
	localparam logic [ADDR_W-1:0] EDGE       = ADDR_W'(KERNEL - 1);

	frame_state_e      state;
	logic              drain_cnt;
	logic [ADDR_W-1:0] pix_addr;

	// stage 1 is the pixel on the memory output, stage 2 the newest window pixel.
	logic              valid1;
	logic              valid2;
	logic [ADDR_W-1:0] row1;
	logic [ADDR_W-1:0] col1;
	logic [ADDR_W-1:0] row2;
	logic [ADDR_W-1:0] col2;
	logic              done_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= IDLE;
			pix_addr  <= '0;
			drain_cnt <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					pix_addr <= '0;
					if (pixel_store_done)
					begin
						state <= STREAM;
					end
				end
				STREAM:
				begin
					drain_cnt <= 1'b0;
					if (pix_addr == LAST_PIXEL)
					begin
						state    <= DRAIN;
						pix_addr <= '0;
					end
					else
					begin
						pix_addr <= pix_addr + 1'b1;
					end
				end
				DRAIN:
				begin
					drain_cnt <= 1'b1;
					if (drain_cnt)
					begin
						state <= IDLE;   // the last pixel has reached the window.
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign read_pixel_addr   = pix_addr;
	assign read_pixel_signal = (state == STREAM);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			valid1 <= read_pixel_signal;
			valid2 <= valid1;
			done_q <= save_enable && (output_row == ADDR_W'(OUT_H - 1))
				&& (output_col == ADDR_W'(OUT_W - 1));
		end
	end

	always_ff @(posedge clk)
	begin
		row1 <= ADDR_W'(pix_addr / IMG_W);
		col1 <= ADDR_W'(pix_addr % IMG_W);
		row2 <= row1;
		col2 <= col1;
	end

	assign window_shift = valid1;   // data returned this cycle enters the window.

	// a full 3x3 window exists once the newest pixel is two rows and two columns in.
	assign save_enable = valid2 && (row2 >= EDGE) && (col2 >= EDGE);
	assign output_row  = row2 - EDGE;
	assign output_col  = col2 - EDGE;

	assign layer1_calculation_done = done_q;

endmodule

`default_nettype wire

/* hw/channel_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_sum (
	input  cnn_types_pkg::data_t partials [cnn_types_pkg::TAPS],
	input  cnn_types_pkg::data_t bias,
	output cnn_types_pkg::data_t sum
);
	import cnn_types_pkg::*;

	data_t level1 [5];
	data_t level2 [2];

	// all additions wrap at DATA_W bits.
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			level1[i] = partials[2*i] + partials[2*i + 1];
		end
		level1[4] = partials[TAPS-1] + bias;   // the odd tap pairs up with the bias.
		level2[0] = level1[0] + level1[1];
		level2[1] = level1[2] + level1[3];
		sum = (level2[0] + level2[1]) + level1[4];
	end

endmodule

`default_nettype wire

/* hw/tap_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_mac (
	input  cnn_types_pkg::pixel_t       pixel,
	input  cnn_types_pkg::tap_weights_t weights,
	output cnn_types_pkg::channel_vec_t partial
);
	import cnn_types_pkg::*;

	// the full product is rescaled and cut back to DATA_W bits.
	function automatic data_t scaled_mul(input data_t a, input data_t b);
		logic signed [2*DATA_W-1:0] prod;
		prod = a * b;
		return data_t'(prod >>> FRAC_BITS);
	endfunction

	always_comb
	begin
		for (int j = 0; j < OUT_CH; j++)
		begin
			partial[j] = '0;
			for (int i = 0; i < IN_CH; i++)
			begin
				partial[j] = partial[j] + scaled_mul(data_t'(pixel[i]), data_t'(weights[j][i]));
			end
		end
	end

endmodule

`default_nettype wire

/* hw/line_window.sv */
`timescale 1ns/1ps
`default_nettype none

module line_window (
	input  logic                  clk,
	input  logic                  rst,
	input  cnn_types_pkg::pixel_t pixel,
	input  logic                  shift,
	output cnn_types_pkg::pixel_t taps [cnn_types_pkg::TAPS]
);
	import cnn_types_pkg::*;

	localparam int DELAY = IMG_W - KERNEL;

	pixel_t win [KERNEL][KERNEL];   // win[dy][dx] with dy = 0 as the oldest row.
	pixel_t row_in [KERNEL];
	pixel_t line_lo [DELAY];        // runs from the bottom row into the middle row.
	pixel_t line_hi [DELAY];        // runs from the middle row into the top row.

	assign row_in[KERNEL-1] = pixel;
	assign row_in[1]        = line_lo[DELAY-1];
	assign row_in[0]        = line_hi[DELAY-1];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < KERNEL; r++)
			begin
				for (int c = 0; c < KERNEL; c++)
				begin
					win[r][c] <= '0;
				end
			end
		end
		else if (shift)
		begin
			for (int r = 0; r < KERNEL; r++)
			begin
				for (int c = 0; c < KERNEL - 1; c++)
				begin
					win[r][c] <= win[r][c + 1];
				end
				win[r][KERNEL-1] <= row_in[r];
			end
		end
	end

	// three window stages plus DELAY stages make exactly one image row.
	always_ff @(posedge clk)
	begin
		if (shift)
		begin
			line_lo[0] <= win[KERNEL-1][0];
			line_hi[0] <= win[1][0];
			for (int i = 1; i < DELAY; i++)
			begin
				line_lo[i] <= line_lo[i - 1];
				line_hi[i] <= line_hi[i - 1];
			end
		end
	end

	always_comb
	begin
		for (int dy = 0; dy < KERNEL; dy++)
		begin
			for (int dx = 0; dx < KERNEL; dx++)
			begin
				taps[dy*KERNEL + dx] = win[dy][dx];
			end
		end
	end

endmodule

`default_nettype wire

/* hw/coef_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module coef_loader #(
	parameter int WORDS = 8,
	parameter int WIDTH = 16
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             store_done,
	input  logic [WIDTH-1:0]                 data,
	output logic [cnn_types_pkg::ADDR_W-1:0] read_addr,
	output logic                             read_signal,
	output logic [WIDTH-1:0]                 coefs [WORDS]
);
	import cnn_types_pkg::*;
	import frame_ctrl_pkg::*;

	localparam int LAST = WORDS - 1;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(LAST);

	load_state_e state;
	logic        shift_en;   // the word for the previous address is on data.

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= LOAD_IDLE;
			read_addr <= '0;
		end
		else
		begin
			case (state)
				LOAD_IDLE, LOAD_HOLD:
				begin
					read_addr <= '0;
					if (store_done)
					begin
						state <= LOAD_RUN;   // a new pulse in hold reloads everything.
					end
				end
				LOAD_RUN:
				begin
					if (read_addr == LAST_ADDR)
					begin
						state     <= LOAD_HOLD;
						read_addr <= '0;
					end
					else
					begin
						read_addr <= read_addr + 1'b1;
					end
				end
				default:
				begin
					state     <= LOAD_IDLE;
					read_addr <= '0;
				end
			endcase
		end
	end

	assign read_signal = (state == LOAD_RUN);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			shift_en <= 1'b0;
		end
		else
		begin
			shift_en <= read_signal;
		end
	end

	// words enter at the top, so word k ends up at index k after the last shift.
	always_ff @(posedge clk)
	begin
		if (shift_en)
		begin
			for (int i = 0; i < LAST; i++)
			begin
				coefs[i] <= coefs[i + 1];
			end
			coefs[LAST] <= data;
		end
	end

endmodule

`default_nettype wire

/* hw/frame_ctrl_pkg.sv */
`default_nettype none

package frame_ctrl_pkg;

	typedef enum logic [1:0]
	{
		IDLE,
		STREAM,
		DRAIN
	} frame_state_e;

	typedef enum logic [1:0]
	{
		LOAD_IDLE,
		LOAD_RUN,
		LOAD_HOLD
	} load_state_e;

	localparam int WEIGHT_WORDS = cnn_types_pkg::TAPS * cnn_types_pkg::OUT_CH;
	localparam int BIAS_WORDS   = cnn_types_pkg::OUT_CH;
	localparam int FRAME_PIXELS = cnn_types_pkg::IMG_W * cnn_types_pkg::IMG_H;

endpackage

`default_nettype wire

/* hw/cnn_types_pkg.sv */
`default_nettype none

package cnn_types_pkg;

	localparam int DATA_W    = 16;
	localparam int IN_CH     = 3;
	localparam int OUT_CH    = 8;
	localparam int KERNEL    = 3;
	localparam int TAPS      = KERNEL * KERNEL;
	localparam int IMG_W     = 32;
	localparam int IMG_H     = 32;
	localparam int OUT_W     = IMG_W - KERNEL + 1;
	localparam int OUT_H     = IMG_H - KERNEL + 1;
	localparam int FRAC_BITS = 8;   // weights and pixels share one fixed point format.
	localparam int ADDR_W    = 16;

	// one channel value in signed fixed point.
	typedef logic signed [DATA_W-1:0] data_t;

	// input channel i sits in the bits starting at DATA_W*i.
	typedef logic [IN_CH-1:0][DATA_W-1:0] pixel_t;

	// output channel j sits in the bits starting at DATA_W*j.
	typedef logic [OUT_CH-1:0][DATA_W-1:0] result_t;

	// one weight word per output channel for a single window tap.
	typedef pixel_t [OUT_CH-1:0] tap_weights_t;

	typedef data_t channel_vec_t [OUT_CH];

endpackage

`default_nettype wire
